//--- filelist.f
rtl/lsab_pkg.sv
rtl/dram_pkg.sv
rtl/lsab_sections.sv
rtl/block_mover.sv
rtl/dram_column_store.sv
rtl/block_mover_top.sv
test/block_mover_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the block mover testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module block_mover_tb -f filelist.f

sim_status=0
out=$(./obj_dir/Vblock_mover_tb) || sim_status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
echo "simulation did not pass (exit status $sim_status)"
exit 1

//--- test/block_mover_tb.sv
// ##########################################################
// testbench of the LSAB to DRAM block mover top level.
// fills the sections, issues blocks and checks the status,
// the full levels and the written columns against a model.
// ##########################################################
module block_mover_tb
	import lsab_pkg::*, dram_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	// requested words of all blocks below.
	localparam int TOTAL_WORDS = 16 + 11 + 12 + 10 + 16 + 32 + 3;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 4 + 200;
	localparam int TOTAL_BLOCKS = 16;

	logic CLK;
	logic RST;
	lsab_write_t lsab_wr;
	logic lsab_wr_strobe;
	logic [LSAB_SECTIONS-1:0] lsab_full;
	block_request_t request;
	logic issue;
	logic working;
	transfer_status_t status;
	word_addr_t read_addr;
	column_t read_column;

	logic [31:0] lfsr_state = 32'h7210;
	lsab_entry_t model_q [LSAB_SECTIONS][$];
	logic [LSAB_SECTIONS-1:0] last_mark = '0;
	column_t model_col [DRAM_COLUMNS];
	logic [1:0] model_known [DRAM_COLUMNS];
	transfer_status_t exp_status;
	int chk_lo;
	int chk_hi;
	int blocks_issued = 0;
	int blocks_checked = 0;

	block_mover_top block_mover_top_inst (
		.CLK(CLK),
		.RST(RST),
		.lsab_wr(lsab_wr),
		.lsab_wr_strobe(lsab_wr_strobe),
		.lsab_full(lsab_full),
		.request(request),
		.issue(issue),
		.working(working),
		.status(status),
		.read_addr(read_addr),
		.read_column(read_column)
	);

	always #4 CLK = ~CLK;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// galois form, taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// words sent are limited by the count and by what the section holds.
	function automatic transfer_status_t expected_status(input block_request_t req,
		input lsab_entry_t q[$], input logic prev_mark);
		transfer_status_t st;
		int sent;
		sent = (int'(req.count) < q.size()) ? int'(req.count) : q.size();
		st.count_sent = block_count_t'(sent);
		st.abrupt_stop = (sent < int'(req.count));
		// int level stays at the last popped mark when nothing pops.
		st.irq = (sent > 0) ? q[sent-1].mark : prev_mark;
		return st;
	endfunction

	// a section is full once it holds LSAB_DEPTH entries.
	function automatic logic [LSAB_SECTIONS-1:0] expected_full();
		logic [LSAB_SECTIONS-1:0] f;
		for (int s = 0; s < LSAB_SECTIONS; s++)
		begin
			f[s] = (model_q[s].size() == LSAB_DEPTH);
		end
		return f;
	endfunction

	// pops the sent words from the model and places them in column halves.
	task automatic model_block(input block_request_t req, input int sent);
		lsab_entry_t e;
		word_addr_t a;
		int idx;
		for (int k = 0; k < sent; k++)
		begin
			e = model_q[req.section].pop_front();
			a = req.start + word_addr_t'(k);
			idx = int'(a >> 1) % DRAM_COLUMNS;
			if (a[0])
			begin
				model_col[idx][15:0] = e.data;
				model_known[idx][0] = 1'b1;
			end
			else
			begin
				model_col[idx][31:16] = e.data;
				model_known[idx][1] = 1'b1;
			end
			last_mark[req.section] = e.mark;
		end
	endtask

	task automatic check_status(input transfer_status_t got, input transfer_status_t exp);
		if (got !== exp)
		begin
			fail_run($sformatf("mismatch status {count_sent,irq,abrupt_stop}: got %h expected %h",
				got, exp));
		end
	endtask

	task automatic check_full(input logic [LSAB_SECTIONS-1:0] got,
		input logic [LSAB_SECTIONS-1:0] exp);
		if (got !== exp)
		begin
			fail_run($sformatf("mismatch lsab_full: got %h expected %h", got, exp));
		end
	endtask

	task automatic check_column(input column_t got, input column_t exp,
		input logic [1:0] known, input int idx);
		if (known[1] && got[31:16] !== exp[31:16])
		begin
			fail_run($sformatf("mismatch read_column[%0d] even half: got %h expected %h",
				idx, got[31:16], exp[31:16]));
		end
		if (known[0] && got[15:0] !== exp[15:0])
		begin
			fail_run($sformatf("mismatch read_column[%0d] odd half: got %h expected %h",
				idx, got[15:0], exp[15:0]));
		end
	endtask

	task automatic write_word(input lsab_section_t sec, input logic mark);
		lsab_entry_t e;
		e.data = random_bits(16);
		e.mark = mark;
		if (model_q[sec].size() >= LSAB_DEPTH)
		begin
			fail_run("the testbench tried to write into a full LSAB section");
		end
		@(posedge CLK);
		lsab_wr.section <= sec;
		lsab_wr.entry <= e;
		lsab_wr_strobe <= 1'b1;
		model_q[sec].push_back(e);
	endtask

	// bit k of marks is the mark of the k-th word.
	task automatic preload(input lsab_section_t sec, input int n, input logic [15:0] marks);
		for (int k = 0; k < n; k++)
		begin
			write_word(sec, marks[k]);
		end
		@(posedge CLK);
		lsab_wr_strobe <= 1'b0;
	endtask

	// side writes go to the next section while the block moves.
	task automatic run_block(input lsab_section_t sec, input word_addr_t start,
		input int count, input int side_n);
		block_request_t req;
		req.start = start;
		req.count = block_count_t'(count);
		req.section = sec;
		// full levels before the block, all earlier writes and pops are done.
		@(negedge CLK);
		check_full(lsab_full, expected_full());
		exp_status = expected_status(req, model_q[sec], last_mark[sec]);
		model_block(req, int'(exp_status.count_sent));
		chk_lo = (int'(start >> 1) > 0) ? int'(start >> 1) - 1 : 0;
		chk_hi = int'((start + word_addr_t'(count)) >> 1) + 1;
		chk_hi = (chk_hi < DRAM_COLUMNS) ? chk_hi : DRAM_COLUMNS - 1;
		blocks_issued++;
		@(posedge CLK);
		request <= req;
		issue <= 1'b1;
		@(posedge CLK);
		issue <= 1'b0;
		for (int k = 0; k < side_n; k++)
		begin
			write_word(lsab_section_t'(sec + 1), random_bits(1) != '0);
		end
		@(posedge CLK);
		lsab_wr_strobe <= 1'b0;
		while (blocks_checked < blocks_issued)
		begin
			@(posedge CLK);
		end
	endtask

	initial
	begin
		CLK = 1'b0;
		RST = 1'b0;
		lsab_wr = '0;
		lsab_wr_strobe = 1'b0;
		request = '0;
		issue = 1'b0;
		read_addr = '0;
		for (int i = 0; i < DRAM_COLUMNS; i++)
		begin
			model_col[i] = '0;
			model_known[i] = 2'b00;
		end
		repeat (8) @(posedge CLK);
		RST <= 1'b1;

		// whole block from an even address, no marks.
		preload(2'd0, 16, 16'h0000);
		run_block(2'd0, 12'h000, 16, 0);
		// odd starts over columns written before.
		preload(2'd1, 11, random_bits(11));
		run_block(2'd1, 12'h003, 6, 0);
		run_block(2'd1, 12'h009, 5, 0);
		// section runs dry before the count.
		preload(2'd2, 5, 16'h0000);
		run_block(2'd2, 12'h000, 12, 0);
		// mark on the last word, then a mark in the middle only.
		preload(2'd3, 6, 16'h0020);
		run_block(2'd3, 12'h020, 6, 0);
		preload(2'd3, 4, 16'h0002);
		run_block(2'd3, 12'h030, 4, 0);
		// all sections with writes to the neighbour section.
		for (int s = 0; s < LSAB_SECTIONS; s++)
		begin
			preload(lsab_section_t'(s), 6, random_bits(6));
		end
		for (int s = 0; s < LSAB_SECTIONS; s++)
		begin
			run_block(lsab_section_t'(s), word_addr_t'(12'h040 + 8 * s), 4, 2);
		end
		for (int s = 0; s < LSAB_SECTIONS; s++)
		begin
			run_block(lsab_section_t'(s), word_addr_t'(12'h060 + 8 * s), 8, 0);
		end
		// zero count over written columns leaves them and the section untouched.
		preload(2'd2, 3, 16'h0005);
		run_block(2'd2, 12'h033, 0, 0);
		run_block(2'd2, 12'h039, 3, 0);

		if (blocks_checked == TOTAL_BLOCKS && blocks_issued == TOTAL_BLOCKS)
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
		begin
			fail_run("the number of checked blocks differs from the number issued");
		end
	end

	// compares status and columns once WORKING falls.
	initial
	begin : compare_proc
		logic was_working;
		was_working = 1'b0;
		forever
		begin
			@(negedge CLK);
			if (was_working && working === 1'b0)
			begin
				check_status(status, exp_status);
				for (int i = chk_lo; i <= chk_hi; i++)
				begin
					@(posedge CLK);
					read_addr <= word_addr_t'(i * 2);
					@(negedge CLK);
					check_column(read_column, model_col[i], model_known[i], i);
				end
				blocks_checked++;
			end
			was_working = (working === 1'b1);
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		fail_run("watchdog expired before all blocks were moved and checked");
	end

endmodule

//--- rtl/block_mover_top.sv
// ##########################################################
// top level of the LSAB to DRAM block mover.
// wires the section FIFOs, the mover and the column store.
// ##########################################################
module block_mover_top
	import lsab_pkg::*, dram_pkg::*;
(
	input logic CLK,
	input logic RST,
	input lsab_write_t lsab_wr,
	input logic lsab_wr_strobe,
	output logic [LSAB_SECTIONS-1:0] lsab_full,
	input block_request_t request,
	input logic issue,
	output logic working,
	output transfer_status_t status,
	input word_addr_t read_addr,
	output column_t read_column
);

	lsab_lines_t lines;
	logic lsab_read;
	lsab_section_t lsab_section;
	lsab_entry_t pop_data;
	logic pop_valid;
	column_write_t column_wr;

	lsab_sections lsab_sections_inst (
		.CLK(CLK),
		.RST(RST),
		.wr(lsab_wr),
		.wr_strobe(lsab_wr_strobe),
		.full(lsab_full),
		.read(lsab_read),
		.section(lsab_section),
		.lines(lines),
		.pop_data(pop_data),
		.pop_valid(pop_valid)
	);

	block_mover block_mover_inst (
		.CLK(CLK),
		.RST(RST),
		.lines(lines),
		.lsab_read(lsab_read),
		.lsab_section(lsab_section),
		.request(request),
		.issue(issue),
		.working(working),
		.status(status),
		.column_wr(column_wr)
	);

	dram_column_store dram_column_store_inst (
		.CLK(CLK),
		.pop_data(pop_data),
		.pop_valid(pop_valid),
		.column_wr(column_wr),
		.read_addr(read_addr),
		.read_column(read_column)
	);

endmodule

//--- rtl/dram_column_store.sv
// ##########################################################
// column memory standing in for DRAM behind its controller.
// pairs the previous and current popped words into a column
// and writes it under byte enables, read side is async.
// ##########################################################
module dram_column_store
	import lsab_pkg::*, dram_pkg::*;
(
	input logic CLK,
	input lsab_entry_t pop_data,
	input logic pop_valid,
	input column_write_t column_wr,
	input word_addr_t read_addr,
	output column_t read_column
);

	column_t mem [DRAM_COLUMNS];
	lsab_word_t prev_word;
	column_t wr_data;
	logic [COL_IDX_W-1:0] wr_idx;
	logic [COL_IDX_W-1:0] rd_idx;

	// the even word was popped one cycle before the odd word.
	always_ff @(posedge CLK)
	begin
		if (pop_valid)
		begin
			prev_word <= pop_data.data;
		end
	end

	assign wr_data = {prev_word, pop_data.data};

	// column index, word address bits above bit 0 modulo the store size.
	assign wr_idx = column_wr.addr[COL_IDX_W:1];
	assign rd_idx = read_addr[COL_IDX_W:1];

	always_ff @(posedge CLK)
	begin
		if (column_wr.request)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (column_wr.byte_en[b])
				begin
					mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
		end
	end

	assign read_column = mem[rd_idx];

endmodule

//--- rtl/block_mover.sv
// ##########################################################
// block mover from an LSAB section into DRAM columns.
// a block starts on a one-cycle issue while idle and ends on
// an empty section or when the count runs out.
// ##########################################################
module block_mover
	import lsab_pkg::*, dram_pkg::*;
(
	input logic CLK,
	input logic RST,
	input lsab_lines_t lines,
	output logic lsab_read,
	output lsab_section_t lsab_section,
	input block_request_t request,
	input logic issue,
	output logic working,
	output transfer_status_t status,
	output column_write_t column_wr
);

	mover_state_t state;
	block_count_t count_req;
	block_count_t len_left;
	word_addr_t track_addr;
	logic take_prev;
	logic take;
	logic read_more;
	logic sec_irq;
	logic trigger;

	assign read_more = (len_left != '0);
	// a word is taken while words remain and the section is not empty.
	assign take = read_more && !lines.stop[lsab_section];
	assign sec_irq = lines.intr[lsab_section];
	// odd address closes a column.
	assign trigger = track_addr[0];

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state <= MOVER_IDLE;
			count_req <= '0;
			len_left <= '0;
			track_addr <= '0;
			take_prev <= 1'b0;
			lsab_read <= 1'b0;
			lsab_section <= '0;
			working <= 1'b0;
			status <= '0;
			column_wr <= '0;
		end
		else
		begin
			// working lags the busy state by a cycle.
			working <= (state == MOVER_MOVING);
			case (state)
				MOVER_IDLE:
				begin
					take_prev <= 1'b0;
					column_wr.request <= 1'b0;
					column_wr.byte_en <= '0;
					if (issue)
					begin
						lsab_section <= request.section;
						count_req <= request.count;
						len_left <= request.count;
						track_addr <= request.start;
						// no read for a zero count, so nothing pops.
						lsab_read <= (request.count != '0);
						state <= MOVER_MOVING;
					end
				end
				MOVER_MOVING:
				begin
					if (take)
					begin
						track_addr <= track_addr + 1'b1;
						len_left <= len_left - 1'b1;
						lsab_read <= (len_left > block_count_t'(1));
					end
					else
					begin
						lsab_read <= 1'b0;
						state <= MOVER_IDLE;
						status.count_sent <= count_req - len_left;
						status.irq <= sec_irq;
						status.abrupt_stop <= read_more;
					end
					take_prev <= take;

					// even half from last cycle's take, odd half from this one.
					if (trigger)
					begin
						column_wr.addr <= {track_addr[11:1], 1'b0};
						column_wr.byte_en <= {take_prev, take_prev, take, take};
						column_wr.request <= 1'b1;
					end
					else
					begin
						column_wr.request <= 1'b0;
					end
				end
				default:
				begin
					state <= MOVER_IDLE;
				end
			endcase
		end
	end

endmodule

//--- rtl/lsab_sections.sv
// ##########################################################
// four LSAB section FIFOs behind one write port.
// the selected section pops on the read level while it holds
// data, the popped entry shows up one cycle later.
// ##########################################################
module lsab_sections
	import lsab_pkg::*;
(
	input logic CLK,
	input logic RST,
	input lsab_write_t wr,
	input logic wr_strobe,
	output logic [LSAB_SECTIONS-1:0] full,
	input logic read,
	input lsab_section_t section,
	output lsab_lines_t lines,
	output lsab_entry_t pop_data,
	output logic pop_valid
);

	localparam int FILL_W = LSAB_PTR_W + 1;

	lsab_entry_t mem [LSAB_SECTIONS][LSAB_DEPTH];
	logic [LSAB_PTR_W-1:0] wr_ptr [LSAB_SECTIONS];
	logic [LSAB_PTR_W-1:0] rd_ptr [LSAB_SECTIONS];
	logic [FILL_W-1:0] fill [LSAB_SECTIONS];
	logic [LSAB_SECTIONS-1:0] empty;
	logic [LSAB_SECTIONS-1:0] intr_q;
	logic push;
	logic pop;

	always_comb
	begin
		for (int s = 0; s < LSAB_SECTIONS; s++)
		begin
			empty[s] = (fill[s] == '0);
			full[s] = (fill[s] == FILL_W'(LSAB_DEPTH));
		end
	end

	// writes to a full section are dropped.
	assign push = wr_strobe && !full[wr.section];
	assign pop = read && !empty[section];

	assign lines.stop = empty;
	assign lines.intr = intr_q;

	// storage, no reset.
	always_ff @(posedge CLK)
	begin
		if (push)
		begin
			mem[wr.section][wr_ptr[wr.section]] <= wr.entry;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (pop)
		begin
			pop_data <= mem[section][rd_ptr[section]];
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			pop_valid <= 1'b0;
			intr_q <= '0;
			for (int s = 0; s < LSAB_SECTIONS; s++)
			begin
				wr_ptr[s] <= '0;
				rd_ptr[s] <= '0;
				fill[s] <= '0;
			end
		end
		else
		begin
			pop_valid <= pop;
			for (int s = 0; s < LSAB_SECTIONS; s++)
			begin
				if (push && wr.section == lsab_section_t'(s))
				begin
					wr_ptr[s] <= wr_ptr[s] + 1'b1;
				end
				if (pop && section == lsab_section_t'(s))
				begin
					rd_ptr[s] <= rd_ptr[s] + 1'b1;
					// int level tracks the mark of the word just popped.
					intr_q[s] <= mem[s][rd_ptr[s]].mark;
				end
				case ({push && wr.section == lsab_section_t'(s),
					pop && section == lsab_section_t'(s)})
					2'b10: fill[s] <= fill[s] + 1'b1;
					2'b01: fill[s] <= fill[s] - 1'b1;
					default: fill[s] <= fill[s];
				endcase
			end
		end
	end

endmodule

//--- rtl/dram_pkg.sv
// ##########################################################
// types and sizes of the DRAM side of the block mover.
// covers addresses, columns, byte enables, the column write
// request, the block command and the transfer status.
// ##########################################################
package dram_pkg;
	import lsab_pkg::*;

	typedef logic [11:0] word_addr_t;

	localparam int COUNT_W = 6;
	typedef logic [COUNT_W-1:0] block_count_t;

	// even word in the upper half, odd word in the lower half.
	typedef logic [31:0] column_t;
	typedef logic [3:0] byte_en_t;

	// the store holds 64 columns, address bits above bit 0 wrap.
	localparam int DRAM_COLUMNS = 64;
	localparam int COL_IDX_W = $clog2(DRAM_COLUMNS);

	typedef struct packed {
		word_addr_t addr;
		byte_en_t byte_en;
		logic request;
	} column_write_t;

	typedef struct packed {
		word_addr_t start;
		block_count_t count;
		lsab_section_t section;
	} block_request_t;

	typedef struct packed {
		block_count_t count_sent;
		logic irq;
		logic abrupt_stop;
	} transfer_status_t;

endpackage

//--- rtl/lsab_pkg.sv
// ##########################################################
// types and sizes of the local staging buffer (LSAB) side.
// covers the section FIFO entries, the write port, the
// per-section status levels and the block mover state.
// ##########################################################
package lsab_pkg;

	// four sections, sixteen entries each.
	localparam int LSAB_SECTIONS = 4;
	localparam int LSAB_DEPTH = 16;
	localparam int LSAB_PTR_W = $clog2(LSAB_DEPTH);

	typedef logic [1:0] lsab_section_t;
	typedef logic [15:0] lsab_word_t;

	// one stored word plus its record mark.
	typedef struct packed {
		lsab_word_t data;
		logic mark;
	} lsab_entry_t;

	// write port, the entry goes to the tail of the section.
	typedef struct packed {
		lsab_section_t section;
		lsab_entry_t entry;
	} lsab_write_t;

	// stop is the empty level, intr the mark of the last popped word.
	typedef struct packed {
		logic [LSAB_SECTIONS-1:0] stop;
		logic [LSAB_SECTIONS-1:0] intr;
	} lsab_lines_t;

	typedef enum logic {
		MOVER_IDLE,
		MOVER_MOVING
	} mover_state_t;

endpackage
